// File: link_cfg_pkg.sv
`default_nettype none

package link_cfg_pkg;

  // depth of each receive queue, which is also the number of credits
  // an endpoint owns for the far side after reset
  localparam int NUM_CREDITS = 8;

  // width of one payload word carried by a data flit
  localparam int DATA_WIDTH = 16;

  // width of one beat on the serial lane
  localparam int LANE_WIDTH = 4;

  // owed credits at which a credit-only flit is sent without waiting for data
  // and it has to stay above 1 so the force condition can clear after a send
  localparam int FORCE_SEND_THRESH = NUM_CREDITS - 4;

endpackage

`default_nettype wire

// File: link_flit_pkg.sv
`default_nettype none

package link_flit_pkg;

  // bits needed to hold any credit count from 0 up to num_credits
  function automatic int credit_width(input int num_credits);
    return $clog2(num_credits + 1);
  endfunction

  // a flit is the credit-only flag, then the credit field, then the data field
  function automatic int flit_width(input int data_width, input int cred_width);
    return 1 + cred_width + data_width;
  endfunction

  // the credit field sits directly above the data field
  function automatic int cred_lsb(input int data_width);
    return data_width;
  endfunction

  // the flag is the top bit of the flit
  function automatic int flag_pos(input int data_width, input int cred_width);
    return data_width + cred_width;
  endfunction

  // lane beats per flit, with the last beat padded with zeros
  function automatic int num_beats(input int flit_w, input int lane_width);
    return (flit_w + lane_width - 1) / lane_width;
  endfunction

  // values for the default configuration
  localparam int CREDIT_WIDTH = credit_width(link_cfg_pkg::NUM_CREDITS);
  localparam int FLIT_WIDTH   = flit_width(link_cfg_pkg::DATA_WIDTH, CREDIT_WIDTH);
  localparam int CRED_LSB     = cred_lsb(link_cfg_pkg::DATA_WIDTH);
  localparam int FLAG_POS     = flag_pos(link_cfg_pkg::DATA_WIDTH, CREDIT_WIDTH);
  localparam int NUM_BEATS    = num_beats(FLIT_WIDTH, link_cfg_pkg::LANE_WIDTH);

endpackage

`default_nettype wire

// File: credit_sync.sv
`timescale 1ns/1ns
`default_nettype none

module credit_sync #(
  parameter int   NUM_CREDITS       = link_cfg_pkg::NUM_CREDITS,
  parameter int   DATA_WIDTH        = link_cfg_pkg::DATA_WIDTH,
  parameter int   FORCE_SEND_THRESH = link_cfg_pkg::FORCE_SEND_THRESH,
  localparam int  CW                = link_flit_pkg::credit_width(NUM_CREDITS)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // word stream from the local source
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  send_valid_i,
  output logic                  send_ready_o,
  // flit stream toward the serializer
  input  logic                  send_ready_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  send_valid_o,
  output logic [CW-1:0]         credits_to_send_o,
  output logic                  credits_only_o,
  // credits returned by the far side and pops of the local receive queue
  input  logic [CW-1:0]         credits_received_i,
  input  logic                  receive_cred_i,
  input  logic                  pop_i
);

  // credits we may still spend on data flits toward the far side
  logic [CW-1:0] avail_q, avail_d;
  // credits we owe the far side, shown on credits_to_send_o
  logic [CW-1:0] to_send_q, to_send_d;
  // owed credits gathered while a flit is stalled, so the visible field holds still
  logic [CW-1:0] hidden_q, hidden_d;
  logic          normal_q, normal_d;
  logic          force_q, force_d;
  logic          send_valid_i_q;
  logic          credit_ok;
  logic          handshake;
  logic [CW-1:0] pop_inc;

  assign handshake         = send_valid_o & send_ready_i;
  assign pop_inc           = CW'(pop_i);
  assign credits_to_send_o = to_send_q;
  assign credits_only_o    = ~normal_d;

  // the source only sees ready when a data flit is on offer
  assign send_ready_o = send_ready_i & normal_d & send_valid_o;

  //////////////////////////////////////////////////
  // flit selection and output valid
  //////////////////////////////////////////////////

  // a credit-only flit carries no payload
  assign data_o = credits_only_o ? '0 : data_i;

  // too many owed credits means they go back even without data
  assign force_d = (to_send_q >= CW'(FORCE_SEND_THRESH));

  // the last credit is kept back unless owed credits ride along with it,
  // otherwise both sides could sit on zero credits and owe each other
  assign credit_ok = (avail_q > CW'(1)) | ((avail_q == CW'(1)) & (to_send_q != '0));

  assign send_valid_o = credit_ok & (send_valid_i | force_d);

  // the flit type is only re-decided on a change of the force condition or on a new
  // source request, so a stalled flit keeps its type until it is taken
  always_comb begin
    normal_d = normal_q;
    if (force_d != force_q) begin
      // data waiting at this point carries the owed credits by itself
      normal_d = send_valid_i;
    end else if (send_valid_i && !send_valid_i_q) begin
      normal_d = ~force_d;
    end
  end

  //////////////////////////////////////////////////
  // credit counters
  //////////////////////////////////////////////////

  // only data flits use a slot in the far queue, so only they cost a credit
  assign avail_d = avail_q + (receive_cred_i ? credits_received_i : '0)
                 - CW'(handshake & ~credits_only_o);

  always_comb begin
    to_send_d = to_send_q;
    hidden_d  = hidden_q;
    if (handshake) begin
      // the visible credits leave with this flit and the hidden ones take their place
      to_send_d = hidden_q + pop_inc;
      hidden_d  = '0;
    end else if (send_valid_o) begin
      // stalled flit so any new pop waits in the hidden counter
      hidden_d = hidden_q + pop_inc;
    end else begin
      to_send_d = to_send_q + pop_inc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      avail_q        <= CW'(NUM_CREDITS);
      to_send_q      <= '0;
      hidden_q       <= '0;
      normal_q       <= 1'b1;
      force_q        <= 1'b0;
      send_valid_i_q <= 1'b0;
    end else begin
      avail_q        <= avail_d;
      to_send_q      <= to_send_d;
      hidden_q       <= hidden_d;
      normal_q       <= normal_d;
      // previous values for edge detection
      force_q        <= force_d;
      send_valid_i_q <= send_valid_i;
    end
  end

endmodule

`default_nettype wire

// File: flit_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module flit_serializer #(
  parameter int FLIT_WIDTH = link_flit_pkg::FLIT_WIDTH,
  parameter int LANE_WIDTH = link_cfg_pkg::LANE_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [FLIT_WIDTH-1:0] flit_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic [LANE_WIDTH-1:0] lane_o,
  output logic                  lane_valid_o
);

  localparam int NB    = link_flit_pkg::num_beats(FLIT_WIDTH, LANE_WIDTH);
  localparam int PAD_W = NB * LANE_WIDTH;
  localparam int CNT_W = (NB > 1) ? $clog2(NB) : 1;

  logic [PAD_W-1:0] shift_q;
  logic [CNT_W-1:0] beat_q;
  logic             busy_q;

  // one flit at a time so the source waits for the whole flit to leave
  assign ready_o      = ~busy_q;
  assign lane_o       = shift_q[LANE_WIDTH-1:0];
  assign lane_valid_o = busy_q;

  // the lowest beat goes out first and the padding ends up in the last beat
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      shift_q <= PAD_W'(flit_i);
    end else if (busy_q) begin
      shift_q <= shift_q >> LANE_WIDTH;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (valid_i && ready_o) begin
      busy_q <= 1'b1;
      beat_q <= '0;
    end else if (busy_q) begin
      // idle again right after the last beat
      if (beat_q == CNT_W'(NB - 1)) begin
        busy_q <= 1'b0;
      end
      beat_q <= beat_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: flit_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module flit_deserializer #(
  parameter int FLIT_WIDTH = link_flit_pkg::FLIT_WIDTH,
  parameter int LANE_WIDTH = link_cfg_pkg::LANE_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [LANE_WIDTH-1:0] lane_i,
  input  logic                  lane_valid_i,
  output logic [FLIT_WIDTH-1:0] flit_o,
  output logic                  flit_valid_o
);

  localparam int NB    = link_flit_pkg::num_beats(FLIT_WIDTH, LANE_WIDTH);
  localparam int PAD_W = NB * LANE_WIDTH;
  localparam int CNT_W = (NB > 1) ? $clog2(NB) : 1;

  logic [PAD_W-1:0] shift_q;
  logic [CNT_W-1:0] beat_q;
  logic             last_beat;

  assign last_beat = lane_valid_i & (beat_q == CNT_W'(NB - 1));

  // beats enter at the top, so after the last one the first beat sits at bit 0
  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      shift_q <= (shift_q >> LANE_WIDTH) | (PAD_W'(lane_i) << (PAD_W - LANE_WIDTH));
    end
  end

  // the padding bits of the last beat are dropped here
  assign flit_o = shift_q[FLIT_WIDTH-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_q       <= '0;
      flit_valid_o <= 1'b0;
    end else begin
      flit_valid_o <= last_beat;
      if (last_beat) begin
        beat_q <= '0;
      end else if (lane_valid_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rx_credit_queue.sv
`timescale 1ns/1ns
`default_nettype none

module rx_credit_queue #(
  parameter int  NUM_CREDITS = link_cfg_pkg::NUM_CREDITS,
  parameter int  DATA_WIDTH  = link_cfg_pkg::DATA_WIDTH,
  localparam int CW          = link_flit_pkg::credit_width(NUM_CREDITS),
  localparam int FW          = link_flit_pkg::flit_width(DATA_WIDTH, CW)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [FW-1:0]         flit_i,
  input  logic                  flit_valid_i,
  output logic [DATA_WIDTH-1:0] out_data_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  pop_o,
  output logic [CW-1:0]         credits_received_o,
  output logic                  receive_cred_o
);

  localparam int CRED_LSB = link_flit_pkg::cred_lsb(DATA_WIDTH);
  localparam int FLAG_POS = link_flit_pkg::flag_pos(DATA_WIDTH, CW);
  localparam int PTR_W    = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;

  logic [DATA_WIDTH-1:0] mem [NUM_CREDITS];
  logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
  logic [CW-1:0]         count_q;
  logic                  cred_only;
  logic                  push;
  logic                  full;

  //////////////////////////////////////////////////
  // flit decode
  //////////////////////////////////////////////////

  // every flit returns credits, data flit or not
  assign cred_only          = flit_i[FLAG_POS];
  assign credits_received_o = flit_i[FLAG_POS-1:CRED_LSB];
  assign receive_cred_o     = flit_valid_i;

  // a credit-only flit never takes a slot
  assign push = flit_valid_i & ~cred_only;

  //////////////////////////////////////////////////
  // circular FIFO
  //////////////////////////////////////////////////

  assign full        = (count_q == CW'(NUM_CREDITS));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem[rd_ptr_q];
  // each word handed to the sink frees one slot and so one credit
  assign pop_o       = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push && !full) begin
      mem[wr_ptr_q] <= flit_i[DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CW'(push & ~full) - CW'(pop_o);
    end
  end

endmodule

`default_nettype wire

// File: link_endpoint.sv
`timescale 1ns/1ns
`default_nettype none

module link_endpoint #(
  parameter int NUM_CREDITS       = link_cfg_pkg::NUM_CREDITS,
  parameter int DATA_WIDTH        = link_cfg_pkg::DATA_WIDTH,
  parameter int LANE_WIDTH        = link_cfg_pkg::LANE_WIDTH,
  parameter int FORCE_SEND_THRESH = link_cfg_pkg::FORCE_SEND_THRESH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [DATA_WIDTH-1:0] in_data_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output logic [DATA_WIDTH-1:0] out_data_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [LANE_WIDTH-1:0] lane_o,
  output logic                  lane_valid_o,
  input  logic [LANE_WIDTH-1:0] lane_i,
  input  logic                  lane_valid_i
);

  localparam int CW = link_flit_pkg::credit_width(NUM_CREDITS);
  localparam int FW = link_flit_pkg::flit_width(DATA_WIDTH, CW);

  // transmit side
  logic [DATA_WIDTH-1:0] tx_data;
  logic [CW-1:0]         tx_credits;
  logic                  tx_cred_only;
  logic                  tx_valid;
  logic                  ser_ready;
  logic [FW-1:0]         tx_flit;

  // receive side
  logic [FW-1:0]         rx_flit;
  logic                  rx_flit_valid;
  logic [CW-1:0]         rx_credits;
  logic                  rx_cred_valid;
  logic                  rx_pop;

  credit_sync #(
    .NUM_CREDITS       (NUM_CREDITS),
    .DATA_WIDTH        (DATA_WIDTH),
    .FORCE_SEND_THRESH (FORCE_SEND_THRESH)
  ) credit_sync_i (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .data_i             (in_data_i),
    .send_valid_i       (in_valid_i),
    .send_ready_o       (in_ready_o),
    .send_ready_i       (ser_ready),
    .data_o             (tx_data),
    .send_valid_o       (tx_valid),
    .credits_to_send_o  (tx_credits),
    .credits_only_o     (tx_cred_only),
    .credits_received_i (rx_credits),
    .receive_cred_i     (rx_cred_valid),
    .pop_i              (rx_pop)
  );

  // flag on top, then the owed credits, then the payload
  assign tx_flit = {tx_cred_only, tx_credits, tx_data};

  flit_serializer #(
    .FLIT_WIDTH (FW),
    .LANE_WIDTH (LANE_WIDTH)
  ) flit_serializer_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flit_i       (tx_flit),
    .valid_i      (tx_valid),
    .ready_o      (ser_ready),
    .lane_o       (lane_o),
    .lane_valid_o (lane_valid_o)
  );

  flit_deserializer #(
    .FLIT_WIDTH (FW),
    .LANE_WIDTH (LANE_WIDTH)
  ) flit_deserializer_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lane_i       (lane_i),
    .lane_valid_i (lane_valid_i),
    .flit_o       (rx_flit),
    .flit_valid_o (rx_flit_valid)
  );

  rx_credit_queue #(
    .NUM_CREDITS (NUM_CREDITS),
    .DATA_WIDTH  (DATA_WIDTH)
  ) rx_credit_queue_i (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .flit_i             (rx_flit),
    .flit_valid_i       (rx_flit_valid),
    .out_data_o         (out_data_o),
    .out_valid_o        (out_valid_o),
    .out_ready_i        (out_ready_i),
    .pop_o              (rx_pop),
    .credits_received_o (rx_credits),
    .receive_cred_o     (rx_cred_valid)
  );

endmodule

`default_nettype wire

// File: credit_link_top.sv
`timescale 1ns/1ns
`default_nettype none

module credit_link_top #(
  parameter int NUM_CREDITS       = link_cfg_pkg::NUM_CREDITS,
  parameter int DATA_WIDTH        = link_cfg_pkg::DATA_WIDTH,
  parameter int LANE_WIDTH        = link_cfg_pkg::LANE_WIDTH,
  parameter int FORCE_SEND_THRESH = link_cfg_pkg::FORCE_SEND_THRESH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // side a
  input  logic [DATA_WIDTH-1:0] in_data_a_i,
  input  logic                  in_valid_a_i,
  output logic                  in_ready_a_o,
  output logic [DATA_WIDTH-1:0] out_data_a_o,
  output logic                  out_valid_a_o,
  input  logic                  out_ready_a_i,
  // side b
  input  logic [DATA_WIDTH-1:0] in_data_b_i,
  input  logic                  in_valid_b_i,
  output logic                  in_ready_b_o,
  output logic [DATA_WIDTH-1:0] out_data_b_o,
  output logic                  out_valid_b_o,
  input  logic                  out_ready_b_i
);

  // lanes named after the direction they carry
  logic [LANE_WIDTH-1:0] lane_ab, lane_ba;
  logic                  lane_valid_ab, lane_valid_ba;

  link_endpoint #(
    .NUM_CREDITS       (NUM_CREDITS),
    .DATA_WIDTH        (DATA_WIDTH),
    .LANE_WIDTH        (LANE_WIDTH),
    .FORCE_SEND_THRESH (FORCE_SEND_THRESH)
  ) endpoint_a (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_data_i    (in_data_a_i),
    .in_valid_i   (in_valid_a_i),
    .in_ready_o   (in_ready_a_o),
    .out_data_o   (out_data_a_o),
    .out_valid_o  (out_valid_a_o),
    .out_ready_i  (out_ready_a_i),
    .lane_o       (lane_ab),
    .lane_valid_o (lane_valid_ab),
    .lane_i       (lane_ba),
    .lane_valid_i (lane_valid_ba)
  );

  link_endpoint #(
    .NUM_CREDITS       (NUM_CREDITS),
    .DATA_WIDTH        (DATA_WIDTH),
    .LANE_WIDTH        (LANE_WIDTH),
    .FORCE_SEND_THRESH (FORCE_SEND_THRESH)
  ) endpoint_b (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_data_i    (in_data_b_i),
    .in_valid_i   (in_valid_b_i),
    .in_ready_o   (in_ready_b_o),
    .out_data_o   (out_data_b_o),
    .out_valid_o  (out_valid_b_o),
    .out_ready_i  (out_ready_b_i),
    .lane_o       (lane_ba),
    .lane_valid_o (lane_valid_ba),
    .lane_i       (lane_ab),
    .lane_valid_i (lane_valid_ab)
  );

endmodule

`default_nettype wire

// File: tb_credit_link_props.sv
`timescale 1ns/1ns
`default_nettype none

module tb_credit_link_props #(
  parameter int VALUE_W    = 16,
  parameter int LEVEL_W    = 4,
  parameter int LEVEL_MAX  = 8,
  // queue instances check push against full and credit instances check the level
  parameter bit QUEUE_SIDE = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // an offer and its acceptance, plus the contents that must hold while it waits
  input  logic               valid_i,
  input  logic               ready_i,
  input  logic [VALUE_W-1:0] value_i,
  // write strobe and full flag of a receive queue
  input  logic               push_i,
  input  logic               full_i,
  // a counter that must never pass LEVEL_MAX
  input  logic [LEVEL_W-1:0] level_i
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  // an offer that is not taken stays up with the same contents on the next edge
  hold_until_taken: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !ready_i) |=> (valid_i && $stable(value_i))
  ) else begin
    $error("offer dropped or changed before it was taken");
    fail_count++;
  end

  if (QUEUE_SIDE) begin : g_queue

    // credits keep the far source from writing into a full queue
    no_push_when_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(push_i && full_i)
    ) else begin
      $error("receive queue written while full");
      fail_count++;
    end

  end else begin : g_level

    level_in_range: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      int'(level_i) <= LEVEL_MAX
    ) else begin
      $error("counter above its limit of %0d", LEVEL_MAX);
      fail_count++;
    end

  end

endmodule

// credits_to_send_o freezes while a flit is stalled, available credits stay in range
bind credit_sync tb_credit_link_props #(
  .VALUE_W    (CW),
  .LEVEL_W    (CW),
  .LEVEL_MAX  (NUM_CREDITS),
  .QUEUE_SIDE (1'b0)
) sync_props_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (send_valid_o),
  .ready_i (send_ready_i),
  .value_i (credits_to_send_o),
  .push_i  (1'b0),
  .full_i  (1'b0),
  .level_i (avail_q)
);

// sink side of endpoint a, together with the queue behind it
bind credit_link_top tb_credit_link_props #(
  .VALUE_W    (DATA_WIDTH),
  .QUEUE_SIDE (1'b1)
) side_a_props_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (out_valid_a_o),
  .ready_i (out_ready_a_i),
  .value_i (out_data_a_o),
  .push_i  (endpoint_a.rx_credit_queue_i.push),
  .full_i  (endpoint_a.rx_credit_queue_i.full),
  .level_i ('0)
);

bind credit_link_top tb_credit_link_props #(
  .VALUE_W    (DATA_WIDTH),
  .QUEUE_SIDE (1'b1)
) side_b_props_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (out_valid_b_o),
  .ready_i (out_ready_b_i),
  .value_i (out_data_b_o),
  .push_i  (endpoint_b.rx_credit_queue_i.push),
  .full_i  (endpoint_b.rx_credit_queue_i.full),
  .level_i ('0)
);

`default_nettype wire

// File: tb_credit_link.sv
`timescale 1ns/1ns
`default_nettype none

module tb_credit_link;

  localparam int NUM_CREDITS  = link_cfg_pkg::NUM_CREDITS;
  localparam int DATA_WIDTH   = link_cfg_pkg::DATA_WIDTH;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 6000;

  logic                       clk = 1'b0;
  logic                       rst_n = 1'b0;
  // index 0 is side a and index 1 is side b
  logic [1:0][DATA_WIDTH-1:0] in_data = '0;
  logic [1:0]                 in_valid = '0;
  logic [1:0]                 in_ready;
  logic [1:0][DATA_WIDTH-1:0] out_data;
  logic [1:0]                 out_valid;
  logic [1:0]                 out_ready = '0;
  // source transfers that happen on the coming rising edge
  logic [1:0]                 taken = '0;

  int seed = 32'h8b59;
  // chance per cycle, in percent, of a new source word and of sink ready
  int src_pct [2] = '{0, 0};
  int snk_pct [2] = '{0, 0};
  int accepted [2] = '{0, 0};
  int delivered [2] = '{0, 0};
  int reset_count = 0;
  int idle_checks = 0;
  int value_errors = 0;
  int other_errors = 0;
  int timeouts = 0;
  int prop_failures;
  // scoreboards, one per direction, oldest word first
  logic [DATA_WIDTH-1:0] sent_ab [$];
  logic [DATA_WIDTH-1:0] sent_ba [$];

  credit_link_top #(
    .NUM_CREDITS       (link_cfg_pkg::NUM_CREDITS),
    .DATA_WIDTH        (link_cfg_pkg::DATA_WIDTH),
    .LANE_WIDTH        (link_cfg_pkg::LANE_WIDTH),
    .FORCE_SEND_THRESH (link_cfg_pkg::FORCE_SEND_THRESH)
  ) credit_link_top_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .in_data_a_i   (in_data[0]),
    .in_valid_a_i  (in_valid[0]),
    .in_ready_a_o  (in_ready[0]),
    .out_data_a_o  (out_data[0]),
    .out_valid_a_o (out_valid[0]),
    .out_ready_a_i (out_ready[0]),
    .in_data_b_i   (in_data[1]),
    .in_valid_b_i  (in_valid[1]),
    .in_ready_b_o  (in_ready[1]),
    .out_data_b_o  (out_data[1]),
    .out_valid_b_o (out_valid[1]),
    .out_ready_b_i (out_ready[1])
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // true in about pct out of 100 calls
  function automatic bit chance(input int pct);
    int unsigned r;
    r = $random(seed);
    return int'(r % 100) < pct;
  endfunction

  task automatic check_low(input string name, input logic actual);
    assert (actual === 1'b0) else begin
      $display("ERR %0t %s expected 0 got %b", $time, name, actual);
      value_errors++;
    end
  endtask

  // in_ready and out_valid of both sides must be low with no source valid
  task automatic check_idle_outputs();
    check_low("in_ready_a_o", in_ready[0]);
    check_low("in_ready_b_o", in_ready[1]);
    check_low("out_valid_a_o", out_valid[0]);
    check_low("out_valid_b_o", out_valid[1]);
  endtask

  // a word leaving side s must be the oldest one sent from the other side
  task automatic take_delivery(input int s);
    logic [DATA_WIDTH-1:0] expected;
    string                 name;
    name = (s == 0) ? "out_data_a_o" : "out_data_b_o";
    if ((s == 1 && sent_ab.size() == 0) || (s == 0 && sent_ba.size() == 0)) begin
      $display("at %0t side %0d delivered a word that was never sent", $time, s);
      other_errors++;
    end else begin
      if (s == 1) begin
        expected = sent_ab.pop_front();
      end else begin
        expected = sent_ba.pop_front();
      end
      assert (out_data[s] === expected) else begin
        $display("ERR %0t %s expected %h got %h", $time, name, expected, out_data[s]);
        value_errors++;
      end
    end
    delivered[s]++;
  endtask

  task automatic set_rates(input int src_a, input int src_b, input int snk_a, input int snk_b);
    src_pct[0] = src_a;
    src_pct[1] = src_b;
    snk_pct[0] = snk_a;
    snk_pct[1] = snk_b;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < RESET_CYCLES + 4) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      timeouts++;
    end
  endtask

  task automatic wait_deliveries(input int need_a, input int need_b, input string what);
    int cycles;
    cycles = 0;
    while ((delivered[0] < need_a || delivered[1] < need_b) && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (delivered[0] < need_a || delivered[1] < need_b) begin
      $display("timeout after %0d cycles during %s, delivered %0d on a and %0d on b",
               WAIT_LIMIT, what, delivered[0], delivered[1]);
      timeouts++;
    end
  endtask

  // every word sent has to come out and no source may still hold valid
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((sent_ab.size() != 0 || sent_ba.size() != 0 || in_valid != 2'b00)
           && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (sent_ab.size() != 0 || sent_ba.size() != 0 || in_valid != 2'b00) begin
      $display("timeout while draining, %0d words a to b and %0d words b to a are missing",
               sent_ab.size(), sent_ba.size());
      timeouts++;
    end
  endtask

  //////////////////////////////////////////////////
  // sources, sinks and scoreboards
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      check_idle_outputs();
      reset_count++;
      if (reset_count == RESET_CYCLES) begin
        rst_n = 1'b1;
      end
    end else begin
      for (int s = 0; s < 2; s++) begin
        // valid holds with the same word until it is taken
        if (!in_valid[s] || taken[s]) begin
          in_valid[s] = chance(src_pct[s]);
          in_data[s]  = DATA_WIDTH'($random(seed));
        end
        out_ready[s] = chance(snk_pct[s]);
      end
      // let the combinational ready paths settle before sampling
      #5;
      if (idle_checks < 2) begin
        check_idle_outputs();
        idle_checks++;
      end
      taken = in_valid & in_ready;
      if (taken[0]) begin
        sent_ab.push_back(in_data[0]);
        accepted[0]++;
      end
      if (taken[1]) begin
        sent_ba.push_back(in_data[1]);
        accepted[1]++;
      end
      for (int s = 0; s < 2; s++) begin
        if (out_valid[s] && out_ready[s]) begin
          take_delivery(s);
        end
      end
      // words in flight are bounded by the far queue plus one flit on the lane
      for (int s = 0; s < 2; s++) begin
        assert (accepted[s] - delivered[1 - s] <= NUM_CREDITS + 1) else begin
          $display("at %0t side %0d has %0d words in flight, more than the far queue holds",
                   $time, s, accepted[s] - delivered[1 - s]);
          other_errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    wait_reset_release();
    repeat (4) @(posedge clk);
    // ordinary two-way traffic
    set_rates(70, 70, 80, 80);
    wait_deliveries(delivered[0] + 40, delivered[1] + 40, "two-way traffic");
    // slow sinks so both receive queues fill up and credits run out
    set_rates(90, 90, 10, 10);
    wait_deliveries(delivered[0] + 30, delivered[1] + 30, "traffic under back-pressure");
    // one-way traffic, so credits come back to a only on credit-only flits
    set_rates(95, 0, 100, 100);
    wait_deliveries(delivered[0], delivered[1] + 3 * NUM_CREDITS + 1, "one-way traffic");
    // both sources always busy and sinks ready half the time
    set_rates(100, 100, 50, 50);
    wait_deliveries(delivered[0] + 150, delivered[1] + 150, "heavy two-way traffic");
    set_rates(0, 0, 100, 100);
    wait_drained();
    prop_failures = credit_link_top_i.endpoint_a.credit_sync_i.sync_props_i.fail_count
                  + credit_link_top_i.endpoint_b.credit_sync_i.sync_props_i.fail_count
                  + credit_link_top_i.side_a_props_i.fail_count
                  + credit_link_top_i.side_b_props_i.fail_count;
    $display("errors: %0d wrong values, %0d other, %0d timeouts, %0d assertion failures",
             value_errors, other_errors, timeouts, prop_failures);
    if (value_errors + other_errors + timeouts + prop_failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
link_cfg_pkg.sv
link_flit_pkg.sv
credit_sync.sv
flit_serializer.sv
flit_deserializer.sv
rx_credit_queue.sv
link_endpoint.sv
credit_link_top.sv
tb_credit_link_props.sv
tb_credit_link.sv

// File: Makefile
TOP = tb_credit_link

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
